// File: drive_array.f
+incdir+include
logic/drive_pkg.sv
logic/time_cnt_generator.sv
logic/pulse_width_encoder.sv
logic/pwm_channel.sv
logic/debug_tap.sv
logic/drive_array.sv
tests/drive_array_tb.sv

// File: include/drive_config.svh
`ifndef DRIVE_CONFIG_SVH
`define DRIVE_CONFIG_SVH

// default number of transducer channels.
`define DRIVE_DEPTH 8

// carrier time counter width, one carrier period is 2**width steps.
`define DRIVE_CNT_WIDTH 8

// half the carrier period.
`define DRIVE_PW_MAX 128

`endif

// File: logic/debug_tap.sv
`timescale 1ns/1ps
`include "drive_config.svh"

module debug_tap #(
  parameter int DEPTH = `DRIVE_DEPTH,
  localparam int SEL_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             pwm_out[DEPTH],
  input  logic [SEL_W-1:0] debug_sel,
  output logic             debug_out
);

  logic sel_ok;

  // selection past the last channel reads as idle.
  assign sel_ok = (int'(debug_sel) < DEPTH);

  always_ff @(posedge clk) begin
    if (rst) begin
      debug_out <= 1'b0;
    end else if (sel_ok) begin
      debug_out <= pwm_out[debug_sel];
    end else begin
      debug_out <= 1'b0;
    end
  end

  a_sel_range: assert property (
    @(posedge clk) disable iff (rst)
    sel_ok
  ) else $error("debug_sel %0d has no channel", debug_sel);

endmodule

// File: logic/drive_array.sv
`timescale 1ns/1ps
`include "drive_config.svh"

module drive_array #(
  parameter int DEPTH = `DRIVE_DEPTH,
  localparam int SEL_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  din_valid,
  input  drive_pkg::intensity_t intensity,
  input  drive_pkg::phase_t     phase,
  input  logic [7:0]            mod_value,
  input  logic [SEL_W-1:0]      debug_sel,
  output logic                  pwm_out[DEPTH],
  output logic                  debug_out,
  output drive_pkg::time_cnt_t  time_cnt
);

  logic                    update;
  drive_pkg::pulse_width_t pulse_width;
  drive_pkg::phase_t       phase_e;
  logic [DEPTH-1:0]        load;

  time_cnt_generator time_cnt_generator (
    .clk(clk),
    .rst(rst),
    .time_cnt(time_cnt),
    .update(update)
  );

  pulse_width_encoder #(
    .DEPTH(DEPTH)
  ) pulse_width_encoder (
    .clk(clk),
    .rst(rst),
    .din_valid(din_valid),
    .intensity(intensity),
    .phase(phase),
    .mod_value(mod_value),
    .pulse_width(pulse_width),
    .phase_e(phase_e),
    .load(load)
  );

  // one channel per transducer, all on the shared counter.
  for (genvar i = 0; i < DEPTH; i++) begin : g_ch
    pwm_channel pwm_channel (
      .clk(clk),
      .rst(rst),
      .time_cnt(time_cnt),
      .update(update),
      .load(load[i]),
      .pulse_width(pulse_width),
      .phase(phase_e),
      .pwm_out(pwm_out[i])
    );
  end

  debug_tap #(
    .DEPTH(DEPTH)
  ) debug_tap (
    .clk(clk),
    .rst(rst),
    .pwm_out(pwm_out),
    .debug_sel(debug_sel),
    .debug_out(debug_out)
  );

endmodule

// File: logic/drive_pkg.sv
`include "drive_config.svh"

package drive_pkg;

  // amplitude request per transducer.
  typedef logic [7:0] intensity_t;

  // phase offset in time counter steps.
  typedef logic [7:0] phase_t;

  // high time in time counter steps, at most half a period.
  typedef logic [7:0] pulse_width_t;

  // carrier time counter.
  typedef logic [`DRIVE_CNT_WIDTH-1:0] time_cnt_t;

endpackage

// File: logic/pulse_width_encoder.sv
`timescale 1ns/1ps
`include "drive_config.svh"

module pulse_width_encoder #(
  parameter int DEPTH = `DRIVE_DEPTH,
  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   din_valid,
  input  drive_pkg::intensity_t  intensity,
  input  drive_pkg::phase_t      phase,
  input  logic [7:0]             mod_value,
  output drive_pkg::pulse_width_t pulse_width,
  output drive_pkg::phase_t      phase_e,
  output logic [DEPTH-1:0]       load
);

  // product of 8 bit intensity and 9 bit level.
  localparam int PROD_W = 17;
  // full scale product maps onto half the carrier period.
  localparam int SHIFT = 9;

  logic [IDX_W-1:0]  beat_idx; // channel the next beat belongs to.

  logic [PROD_W-1:0] prod_s1;
  drive_pkg::phase_t phase_s1;
  logic              valid_s1;
  logic [IDX_W-1:0]  idx_s1;

  // beat counter, wraps after the last channel.
  always_ff @(posedge clk) begin
    if (rst) begin
      beat_idx <= '0;
    end else if (din_valid) begin
      if (beat_idx == IDX_W'(DEPTH - 1)) begin
        beat_idx <= '0;
      end else begin
        beat_idx <= beat_idx + 1'b1;
      end
    end
  end

  // stage one, scale by the modulation level.
  always_ff @(posedge clk) begin
    prod_s1  <= intensity * ({1'b0, mod_value} + 9'd1);
    phase_s1 <= phase;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_s1 <= 1'b0;
      idx_s1   <= '0;
    end else begin
      valid_s1 <= din_valid;
      idx_s1   <= beat_idx;
    end
  end

  // stage two, width and channel strobe.
  always_ff @(posedge clk) begin
    pulse_width <= prod_s1[PROD_W-1:SHIFT];
    phase_e     <= phase_s1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      load <= '0;
    end else begin
      load <= '0;
      if (valid_s1) begin
        load[idx_s1] <= 1'b1;
      end
    end
  end

  // at most one channel takes each beat.
  a_load_onehot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(load)
  ) else $error("load not one-hot: %b", load);

  // the width handed to a channel stays within half a period.
  a_pw_range: assert property (
    @(posedge clk) disable iff (rst)
    (|load) |-> (pulse_width <= `DRIVE_PW_MAX)
  ) else $error("pulse_width %0d out of range", pulse_width);

endmodule

// File: logic/pwm_channel.sv
`timescale 1ns/1ps
`include "drive_config.svh"

module pwm_channel (
  input  logic                    clk,
  input  logic                    rst,
  input  drive_pkg::time_cnt_t    time_cnt,
  input  logic                    update,
  input  logic                    load,
  input  drive_pkg::pulse_width_t pulse_width,
  input  drive_pkg::phase_t       phase,
  output logic                    pwm_out
);

  drive_pkg::pulse_width_t width_shadow;
  drive_pkg::phase_t       phase_shadow;
  drive_pkg::pulse_width_t width_act;
  drive_pkg::phase_t       phase_act;
  drive_pkg::time_cnt_t    t_rel; // counter seen from the pulse start.

  always_ff @(posedge clk) begin
    if (rst) begin
      width_shadow <= '0;
      phase_shadow <= '0;
    end else if (load) begin
      width_shadow <= pulse_width;
      phase_shadow <= phase;
    end
  end

  // swap only at the period wrap so a pulse is never cut.
  always_ff @(posedge clk) begin
    if (rst) begin
      width_act <= '0;
      phase_act <= '0;
    end else if (update) begin
      width_act <= width_shadow;
      phase_act <= phase_shadow;
    end
  end

  assign t_rel = time_cnt - phase_act; // mod 256, so windows wrap past 255.

  always_ff @(posedge clk) begin
    if (rst) begin
      pwm_out <= 1'b0;
    end else begin
      pwm_out <= (t_rel < width_act);
    end
  end

  a_width_range: assert property (
    @(posedge clk) disable iff (rst)
    width_act <= `DRIVE_PW_MAX
  ) else $error("active width %0d out of range", width_act);

endmodule

// File: logic/time_cnt_generator.sv
`timescale 1ns/1ps

module time_cnt_generator (
  input  logic                clk,
  input  logic                rst,
  output drive_pkg::time_cnt_t time_cnt,
  output logic                update
);

  localparam drive_pkg::time_cnt_t CNT_LAST = '1;

  always_ff @(posedge clk) begin
    if (rst) begin
      time_cnt <= '0;
      update   <= 1'b0;
    end else begin
      time_cnt <= time_cnt + 1'b1; // wraps at the top.
      // raised one step early so it lines up with the last count.
      update   <= (time_cnt == CNT_LAST - 1'b1);
    end
  end

  // update marks the wrap cycle and nothing else.
  a_update_at_wrap: assert property (
    @(posedge clk) disable iff (rst)
    update |-> (time_cnt == CNT_LAST)
  ) else $error("update high with time_cnt %0d", time_cnt);

endmodule

// File: run.sh
#!/bin/sh
# Build and run the drive array testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module drive_array_tb \
  -f drive_array.f \
  -o sim_drive_array

./obj_dir/sim_drive_array | tee sim.log

if grep -q '^test passed$' sim.log; then
  exit 0
else
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

// File: tests/drive_array_tb.sv
`timescale 1ns/1ps
`include "drive_config.svh"

module drive_array_tb;

  localparam int DEPTH = `DRIVE_DEPTH;
  localparam int SEL_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int PERIOD = 1 << `DRIVE_CNT_WIDTH;
  // six tests of up to about two carrier periods, plus margin.
  localparam int CYCLE_LIMIT = 4000;

  logic                  clk;
  logic                  rst;
  logic                  din_valid;
  drive_pkg::intensity_t intensity;
  drive_pkg::phase_t     phase;
  logic [7:0]            mod_value;
  logic [SEL_W-1:0]      debug_sel;
  logic                  pwm_out[DEPTH];
  logic                  debug_out;
  drive_pkg::time_cnt_t  time_cnt;

  logic [31:0] rng_state = 32'h55f9_f270;
  string       test_name = "reset";
  string       cur_test = "reset";
  int          pwm_errors = 0;
  int          cnt_errors = 0;
  int          debug_errors = 0;
  int          cycle_count = 0;

  // reference model state.
  logic                  model_ready = 1'b0;
  drive_pkg::time_cnt_t  m_cnt;
  logic                  m_upd;
  int                    beat_idx;
  logic                  s1_valid, s2_valid;
  int                    s1_idx, s2_idx;
  drive_pkg::intensity_t s1_int, s2_int;
  logic [7:0]            s1_mod, s2_mod;
  drive_pkg::phase_t     s1_ph, s2_ph;
  drive_pkg::intensity_t sh_int[DEPTH], act_int[DEPTH];
  logic [7:0]            sh_mod[DEPTH], act_mod[DEPTH];
  drive_pkg::phase_t     sh_ph[DEPTH], act_ph[DEPTH];
  logic                  exp_pwm[DEPTH];
  logic                  exp_debug;

  drive_array #(
    .DEPTH(DEPTH)
  ) drive_array_i (
    .clk(clk),
    .rst(rst),
    .din_valid(din_valid),
    .intensity(intensity),
    .phase(phase),
    .mod_value(mod_value),
    .debug_sel(debug_sel),
    .pwm_out(pwm_out),
    .debug_out(debug_out),
    .time_cnt(time_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] next_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[7:0];
  endfunction

  // level of one channel at counter t, from intensity, level and phase.
  function automatic logic expected_level(input drive_pkg::intensity_t inten,
                                          input logic [7:0] mod,
                                          input drive_pkg::phase_t ph,
                                          input drive_pkg::time_cnt_t t);
    int width;
    int rel;
    width = (int'(inten) * (int'(mod) + 1)) >> 9;
    rel = (int'(t) - int'(ph) + PERIOD) % PERIOD; // window may wrap past 255.
    return (rel < width);
  endfunction

  task automatic check_pwm(input int ch, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: pwm_out[%0d] expected %0b, actual %0b", cur_test, ch, exp, act);
      pwm_errors++;
    end
  endtask

  task automatic check_time_cnt(input drive_pkg::time_cnt_t exp,
                                input drive_pkg::time_cnt_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: time_cnt expected %0d, actual %0d", cur_test, exp, act);
      cnt_errors++;
    end
  endtask

  task automatic check_debug(input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: debug_out expected %0b, actual %0b", cur_test, exp, act);
      debug_errors++;
    end
  endtask

  // model follows the driven inputs edge by edge.
  always @(posedge clk) begin
    cur_test = test_name;
    if (rst) begin
      model_ready = 1'b1;
      m_cnt = '0;
      m_upd = 1'b0;
      beat_idx = 0;
      s1_valid = 1'b0;
      s2_valid = 1'b0;
      exp_debug = 1'b0;
      for (int ch = 0; ch < DEPTH; ch++) begin
        sh_int[ch] = '0;
        sh_mod[ch] = '0;
        sh_ph[ch] = '0;
        act_int[ch] = '0;
        act_mod[ch] = '0;
        act_ph[ch] = '0;
        exp_pwm[ch] = 1'b0;
      end
    end else begin
      if (int'(debug_sel) < DEPTH) begin
        exp_debug = exp_pwm[debug_sel]; // previous cycle's level.
      end else begin
        exp_debug = 1'b0;
      end
      for (int ch = 0; ch < DEPTH; ch++) begin
        exp_pwm[ch] = expected_level(act_int[ch], act_mod[ch], act_ph[ch], m_cnt);
      end
      if (m_upd) begin
        for (int ch = 0; ch < DEPTH; ch++) begin
          act_int[ch] = sh_int[ch];
          act_mod[ch] = sh_mod[ch];
          act_ph[ch] = sh_ph[ch];
        end
      end
      if (s2_valid) begin
        sh_int[s2_idx] = s2_int;
        sh_mod[s2_idx] = s2_mod;
        sh_ph[s2_idx] = s2_ph;
      end
      s2_valid = s1_valid;
      s2_idx = s1_idx;
      s2_int = s1_int;
      s2_mod = s1_mod;
      s2_ph = s1_ph;
      s1_valid = din_valid;
      s1_idx = beat_idx;
      s1_int = intensity;
      s1_mod = mod_value;
      s1_ph = phase;
      if (din_valid) begin
        beat_idx = (beat_idx == DEPTH - 1) ? 0 : beat_idx + 1;
      end
      m_upd = (m_cnt == drive_pkg::time_cnt_t'(PERIOD - 2));
      m_cnt = m_cnt + 1'b1;
    end
  end

  // outputs are settled by the falling edge.
  always @(negedge clk) begin
    if (model_ready) begin
      check_time_cnt(m_cnt, time_cnt);
      for (int ch = 0; ch < DEPTH; ch++) begin
        check_pwm(ch, exp_pwm[ch], pwm_out[ch]);
      end
      check_debug(exp_debug, debug_out);
    end
  end

  initial begin
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run reached %0d cycles without finishing", CYCLE_LIMIT);
    $display("test failed");
    $finish;
  end

  task automatic wait_cnt(input drive_pkg::time_cnt_t value);
    while (time_cnt != value) begin
      @(negedge clk);
    end
  endtask

  task automatic wait_wrap();
    @(negedge clk);
    wait_cnt('0);
  endtask

  // one beat per channel, optional random gaps.
  task automatic send_frame(input int gap_max, input bit zero_some);
    logic [7:0] inten;
    logic [7:0] ph;
    int         gap;
    for (int ch = 0; ch < DEPTH; ch++) begin
      inten = next_byte();
      ph = next_byte();
      if (zero_some && (ch % 3 == 1)) begin
        inten = 8'd0;
      end
      if (ch == DEPTH - 1) begin
        ph = {4'hf, ph[3:0]}; // forces a window across the wrap.
      end
      din_valid = 1'b1;
      intensity = inten;
      phase = ph;
      @(negedge clk);
      din_valid = 1'b0;
      if (gap_max > 0) begin
        gap = int'(next_byte()) % (gap_max + 1);
        repeat (gap) @(negedge clk);
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    din_valid = 1'b0;
    intensity = '0;
    phase = '0;
    mod_value = '0;
    debug_sel = '0;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    test_name = "reset_idle";
    wait_wrap();

    test_name = "random_frame";
    mod_value = 8'd255;
    wait_cnt(8'd128);
    send_frame(0, 1'b0);
    wait_wrap();
    wait_wrap();

    test_name = "frame_swap";
    wait_cnt(8'd200);
    send_frame(0, 1'b0);
    wait_wrap();
    wait_wrap();

    test_name = "mod_scaling";
    mod_value = 8'd0;
    send_frame(0, 1'b1);
    wait_wrap();
    mod_value = 8'd127;
    send_frame(0, 1'b1);
    wait_wrap();
    mod_value = 8'd64;
    send_frame(0, 1'b1);
    wait_wrap();
    mod_value = 8'd200;
    send_frame(0, 1'b1);
    wait_wrap();
    wait_wrap();

    test_name = "beat_order";
    mod_value = 8'd255;
    send_frame(3, 1'b0);
    wait_wrap();
    send_frame(0, 1'b0);
    send_frame(0, 1'b0); // second frame overwrites the first.
    wait_wrap();
    wait_wrap();

    test_name = "debug_sweep";
    for (int sel = 0; sel < DEPTH; sel++) begin
      debug_sel = SEL_W'(sel);
      repeat (32) @(negedge clk);
    end

    repeat (2) @(negedge clk);
    @(posedge clk); // last falling edge checks are done.
    $display("errors: pwm %0d, time_cnt %0d, debug %0d",
             pwm_errors, cnt_errors, debug_errors);
    if (pwm_errors + cnt_errors + debug_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
